/* tests/rvvi_trace_bridge_stim.txt */
# name vld ord tED dc ec iI icz nmp rd rd_wdata csr_wmsk csr_wdat csr_rdat irq dreq
#   expected: trap csr0 csr_wb x_wb x_wdata nmi_cause NnFf(nmi,chg,ifault,chg) nets HIh
gpr_x5 1 01 000 0 00 00 000 0 05 12345678 00000000 00000000 00000000 00000000 0 0 00000000 0 00000020 12345678 000 0000 00000 000
gpr_x0 1 02 000 0 00 00 000 0 00 deadbeef 00000000 00000000 00000000 00000000 0 0 00000000 0 00000000 12345678 000 0000 00000 000
gpr_idle 0 03 000 0 00 00 000 0 07 cafef00d 00000000 00000000 00000000 00000000 0 0 00000000 0 00000000 12345678 000 0000 00000 000
trap_exc 1 03 110 0 02 00 000 0 00 00000000 00000000 00000000 00000000 00000000 0 1 00000000 0 00000000 12345678 000 0000 00000 000
trap_ebreak 1 04 101 1 00 00 000 0 00 00000000 00000000 00000000 00000000 00000000 0 1 00000000 0 00000000 12345678 000 0000 00000 000
trap_trigger 1 05 101 2 00 00 000 0 00 00000000 00000000 00000000 00000000 00000000 0 1 00000000 0 00000000 12345678 000 0000 00000 000
trap_dbg3 1 06 101 3 00 00 000 0 00 00000000 00000000 00000000 00000000 00000000 0 0 00000000 0 00000000 12345678 000 0000 00000 000
plain_retire 1 07 000 0 00 00 000 0 00 00000000 00000000 00000000 00000000 00000000 0 0 00000000 0 00000000 12345678 000 0000 00000 000
csr_merge 1 08 000 0 00 00 000 0 00 00000000 ffff0000 aaaa1111 2222bbbb 00000000 0 0 aaaabbbb 1 00000000 12345678 000 0000 00000 000
csr_hold 0 09 000 0 00 00 000 0 00 00000000 00000000 00000000 00000000 00000000 0 0 00000000 1 00000000 12345678 000 0000 00000 000
csr_clear 1 09 000 0 00 00 000 0 00 00000000 00000000 00000000 00000000 00000000 0 0 00000000 0 00000000 12345678 000 0000 00000 000
nmi_load 1 0a 000 0 00 11 400 0 00 00000000 00000000 00000000 00000000 00000000 0 0 00000000 0 00000000 12345678 400 1100 00000 000
nmi_repeat 1 0a 000 0 00 00 000 0 00 00000000 00000000 00000000 00000000 00000000 0 0 00000000 0 00000000 12345678 400 1000 00000 000
nmi_drop 1 0b 000 0 00 00 000 0 00 00000000 00000000 00000000 00000000 00000000 0 0 00000000 0 00000000 12345678 400 0100 00000 000
ifault_set 1 0c 110 0 18 00 000 0 00 00000000 00000000 00000000 00000000 00000000 0 1 00000000 0 00000000 12345678 400 0011 00000 000
ifault_clear 1 0d 000 0 00 00 000 0 00 00000000 00000000 00000000 00000000 00000000 0 0 00000000 0 00000000 12345678 400 0001 00000 000
irq11_set 1 0e 000 0 00 00 000 0 00 00000000 00000000 00000000 00000000 00000800 0 0 00000000 0 00000000 12345678 400 0000 00004 010
irq11_clear 1 0f 000 0 00 00 000 0 00 00000000 00000000 00000000 00000000 00000000 0 0 00000000 0 00000000 12345678 400 0000 00000 010
irq0_toggle 1 10 000 0 00 00 000 0 00 00000000 00000000 00000000 00000000 00000001 0 0 00000000 0 00000000 12345678 400 0000 00000 000
dreq_set 1 11 000 0 00 00 000 0 00 00000000 00000000 00000000 00000000 00000001 1 0 00000000 0 00000000 12345678 400 0000 00000 101
dreq_clear 1 12 000 0 00 00 000 0 00 00000000 00000000 00000000 00000000 00000001 0 0 00000000 0 00000000 12345678 400 0000 00000 001

/* compile.f */
logic/rvvi_bridge_pkg.sv
logic/retire_qualifier.sv
logic/csr_trace_merge.sv
logic/gpr_write_capture.sv
logic/bus_fault_tracker.sv
logic/irq_net_monitor.sv
logic/rvvi_trace_bridge.sv
tests/rvvi_trace_bridge_assertions.sv
tests/rvvi_trace_bridge_tb.sv

/* Bender.yml */
package:
  name: rvvi_trace_bridge

sources:
  - logic/rvvi_bridge_pkg.sv
  - logic/retire_qualifier.sv
  - logic/csr_trace_merge.sv
  - logic/gpr_write_capture.sv
  - logic/bus_fault_tracker.sv
  - logic/irq_net_monitor.sv
  - logic/rvvi_trace_bridge.sv
  - target: test
    files:
      - tests/rvvi_trace_bridge_assertions.sv
      - tests/rvvi_trace_bridge_tb.sv

/* tests/rvvi_trace_bridge_tb.sv */
`timescale 1ns/1ns

module rvvi_trace_bridge_tb;
   import rvvi_bridge_pkg::*;

   localparam int unsigned CLK_PERIOD_NS   = 4;
   localparam int unsigned RESET_CYCLES    = 16;
   // Longer than half a period and off the clock grid
   localparam int unsigned EDGE_TIMEOUT_NS = 3;
   localparam int unsigned RAND_SEED       = 32'h14e77486;
   localparam string       STIM_FILE       = "tests/rvvi_trace_bridge_stim.txt";

   logic                rvvi = 1'b0;
   logic                arst_n_i;
   logic                valid_i;
   order_t              order_i;
   xword_t              insn_i;
   xword_t              pc_rdata_i;
   xword_t              pc_wdata_i;
   logic                trap_i;
   logic                trap_exception_i;
   logic                trap_debug_i;
   dbg_cause_t          trap_debug_cause_i;
   exc_cause_t          trap_exc_cause_i;
   logic                intr_i;
   logic                intr_interrupt_i;
   intr_cause_t         intr_cause_i;
   logic [1:0]          mode_i;
   logic [1:0]          nmip_i;
   xword_t              csr_rdata_i [NUM_CSR];
   xword_t              csr_wdata_i [NUM_CSR];
   xword_t              csr_rmask_i [NUM_CSR];
   xword_t              csr_wmask_i [NUM_CSR];
   gpr_idx_t            rd_addr_i;
   xword_t              rd_wdata_i;
   logic [31:0]         irq_i;
   logic                debug_req_i;

   logic                valid_o;
   order_t              order_o;
   xword_t              insn_o;
   xword_t              pc_rdata_o;
   xword_t              pc_wdata_o;
   logic                trap_o;
   logic                intr_o;
   logic [1:0]          mode_o;
   xword_t              csr_o [NUM_CSR];
   logic [NUM_CSR-1:0]  csr_wb_o;
   gpr_mask_t           x_wb_o;
   xword_t              x_wdata_o;
   logic                nmi_o;
   intr_cause_t         nmi_cause_o;
   logic                nmi_change_o;
   logic                ifault_o;
   logic                ifault_change_o;
   irq_nets_t           irq_nets_o;
   logic                haltreq_o;
   logic                irq_change_o;
   logic                haltreq_change_o;

   // One stimulus record, inputs then expected outputs
   string               test_name;
   logic                rec_valid;
   order_t              rec_order;
   logic [2:0]          rec_trap_bits;
   dbg_cause_t          rec_dbg_cause;
   exc_cause_t          rec_exc_cause;
   logic [1:0]          rec_intr_bits;
   intr_cause_t         rec_intr_cause;
   logic [1:0]          rec_nmip;
   gpr_idx_t            rec_rd;
   xword_t              rec_rd_wdata;
   xword_t              rec_csr_wmask;
   xword_t              rec_csr_wdata;
   xword_t              rec_csr_rdata;
   xword_t              rec_irq;
   logic                rec_dreq;
   logic                exp_trap;
   xword_t              exp_csr;
   logic [3:0]          exp_csr_wb;
   gpr_mask_t           exp_x_wb;
   xword_t              exp_x_wdata;
   intr_cause_t         exp_nmi_cause;
   logic [3:0]          exp_fault_bits;
   irq_nets_t           exp_nets;
   logic [2:0]          exp_net_bits;

   xword_t              rnd_insn;
   xword_t              rnd_pc_rdata;
   xword_t              rnd_pc_wdata;
   logic [1:0]          rnd_mode;
   xword_t              rnd_csr_rdata [NUM_CSR];
   logic                clock_toggled;

   rvvi_trace_bridge rvvi_trace_bridge_inst (
      .rvvi               (rvvi),
      .arst_n_i           (arst_n_i),
      .valid_i            (valid_i),
      .order_i            (order_i),
      .insn_i             (insn_i),
      .pc_rdata_i         (pc_rdata_i),
      .pc_wdata_i         (pc_wdata_i),
      .trap_i             (trap_i),
      .trap_exception_i   (trap_exception_i),
      .trap_debug_i       (trap_debug_i),
      .trap_debug_cause_i (trap_debug_cause_i),
      .trap_exc_cause_i   (trap_exc_cause_i),
      .intr_i             (intr_i),
      .intr_interrupt_i   (intr_interrupt_i),
      .intr_cause_i       (intr_cause_i),
      .mode_i             (mode_i),
      .nmip_i             (nmip_i),
      .csr_rdata_i        (csr_rdata_i),
      .csr_wdata_i        (csr_wdata_i),
      .csr_rmask_i        (csr_rmask_i),
      .csr_wmask_i        (csr_wmask_i),
      .rd_addr_i          (rd_addr_i),
      .rd_wdata_i         (rd_wdata_i),
      .irq_i              (irq_i),
      .debug_req_i        (debug_req_i),
      .valid_o            (valid_o),
      .order_o            (order_o),
      .insn_o             (insn_o),
      .pc_rdata_o         (pc_rdata_o),
      .pc_wdata_o         (pc_wdata_o),
      .trap_o             (trap_o),
      .intr_o             (intr_o),
      .mode_o             (mode_o),
      .csr_o              (csr_o),
      .csr_wb_o           (csr_wb_o),
      .x_wb_o             (x_wb_o),
      .x_wdata_o          (x_wdata_o),
      .nmi_o              (nmi_o),
      .nmi_cause_o        (nmi_cause_o),
      .nmi_change_o       (nmi_change_o),
      .ifault_o           (ifault_o),
      .ifault_change_o    (ifault_change_o),
      .irq_nets_o         (irq_nets_o),
      .haltreq_o          (haltreq_o),
      .irq_change_o       (irq_change_o),
      .haltreq_change_o   (haltreq_change_o)
   );

   bind rvvi_trace_bridge rvvi_trace_bridge_assertions rvvi_trace_bridge_assertions_inst (.*);

   initial begin
      forever begin
         #(CLK_PERIOD_NS / 2) rvvi = ~rvvi;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////////////////////////////////////////
   task stop_on_failure(input string reason);
      $display("%s", reason);
      $display("RESULT: FAIL");
      $fatal(1, "simulation stopped");
   endtask

   task check_value(input string test, input string signal_name,
                    input logic [63:0] expected, input logic [63:0] actual);
      if (actual !== expected) begin
         $display("Error: test %s, %s expected %h actual %h",
                  test, signal_name, expected, actual);
         stop_on_failure("output mismatch");
      end
   endtask

   // Steps over clock transitions until the clock has fallen
   task wait_falling_edge();
      int unsigned hops;
      hops = 0;
      do begin
         clock_toggled = 1'b0;
         fork
            begin
               @(rvvi);
               clock_toggled = 1'b1;
            end
            begin
               #(EDGE_TIMEOUT_NS);
            end
         join_any
         disable fork;
         hops++;
         if (!clock_toggled || hops > 2) begin
            stop_on_failure("Clock stopped toggling while waiting for a falling edge");
         end
      end while (rvvi !== 1'b0);
   endtask

   task drive_record();
      rnd_insn     = xword_t'($urandom);
      rnd_pc_rdata = xword_t'($urandom);
      rnd_pc_wdata = xword_t'($urandom);
      rnd_mode     = 2'($urandom);
      valid_i            = rec_valid;
      order_i            = rec_order;
      insn_i             = rnd_insn;
      pc_rdata_i         = rnd_pc_rdata;
      pc_wdata_i         = rnd_pc_wdata;
      mode_i             = rnd_mode;
      trap_i             = rec_trap_bits[2];
      trap_exception_i   = rec_trap_bits[1];
      trap_debug_i       = rec_trap_bits[0];
      trap_debug_cause_i = rec_dbg_cause;
      trap_exc_cause_i   = rec_exc_cause;
      intr_i             = rec_intr_bits[1];
      intr_interrupt_i   = rec_intr_bits[0];
      intr_cause_i       = rec_intr_cause;
      nmip_i             = rec_nmip;
      rd_addr_i          = rec_rd;
      rd_wdata_i         = rec_rd_wdata;
      irq_i              = rec_irq;
      debug_req_i        = rec_dreq;
      // Slot 0 is traced from the file, the other slots see only read data
      for (int s = 0; s < NUM_CSR; s++) begin
         rnd_csr_rdata[s] = xword_t'($urandom);
         csr_rmask_i[s] = '0;
         csr_wmask_i[s] = (s == 0) ? rec_csr_wmask : '0;
         csr_wdata_i[s] = (s == 0) ? rec_csr_wdata : '0;
         csr_rdata_i[s] = (s == 0) ? rec_csr_rdata : rnd_csr_rdata[s];
      end
   endtask

   task check_record();
      if (rvvi_trace_bridge_inst.rvvi_trace_bridge_assertions_inst.fail_count != 0) begin
         stop_on_failure("A bound assertion on the trace outputs failed");
      end
      check_value(test_name, "valid_o", 64'(rec_valid), 64'(valid_o));
      check_value(test_name, "order_o", rec_order, order_o);
      check_value(test_name, "insn_o", 64'(rnd_insn), 64'(insn_o));
      check_value(test_name, "pc_rdata_o", 64'(rnd_pc_rdata), 64'(pc_rdata_o));
      check_value(test_name, "pc_wdata_o", 64'(rnd_pc_wdata), 64'(pc_wdata_o));
      check_value(test_name, "mode_o", 64'(rnd_mode), 64'(mode_o));
      check_value(test_name, "intr_o", 64'(rec_intr_bits[1]), 64'(intr_o));
      check_value(test_name, "trap_o", 64'(exp_trap), 64'(trap_o));
      check_value(test_name, "csr_o[0]", 64'(exp_csr), 64'(csr_o[0]));
      // No write mask on the other slots, so the read data passes
      for (int s = 1; s < NUM_CSR; s++) begin
         check_value(test_name, $sformatf("csr_o[%0d]", s),
                     64'(rnd_csr_rdata[s]), 64'(csr_o[s]));
      end
      check_value(test_name, "csr_wb_o", 64'(exp_csr_wb), 64'(csr_wb_o));
      check_value(test_name, "x_wb_o", 64'(exp_x_wb), 64'(x_wb_o));
      check_value(test_name, "x_wdata_o", 64'(exp_x_wdata), 64'(x_wdata_o));
      check_value(test_name, "nmi_o", 64'(exp_fault_bits[3]), 64'(nmi_o));
      check_value(test_name, "nmi_cause_o", 64'(exp_nmi_cause), 64'(nmi_cause_o));
      check_value(test_name, "nmi_change_o", 64'(exp_fault_bits[2]), 64'(nmi_change_o));
      check_value(test_name, "ifault_o", 64'(exp_fault_bits[1]), 64'(ifault_o));
      check_value(test_name, "ifault_change_o", 64'(exp_fault_bits[0]), 64'(ifault_change_o));
      check_value(test_name, "irq_nets_o", 64'(exp_nets), 64'(irq_nets_o));
      check_value(test_name, "haltreq_o", 64'(exp_net_bits[2]), 64'(haltreq_o));
      check_value(test_name, "irq_change_o", 64'(exp_net_bits[1]), 64'(irq_change_o));
      check_value(test_name, "haltreq_change_o", 64'(exp_net_bits[0]), 64'(haltreq_change_o));
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Stimulus loop
   ////////////////////////////////////////////////////////////////////////////
   initial begin
      int          fd;
      int          fields;
      int unsigned records;
      int unsigned rand_seed;
      string       line;

      arst_n_i = 1'b1;
      rec_valid = 1'b0;
      rec_order = '0;
      rec_trap_bits = '0;
      rec_dbg_cause = '0;
      rec_exc_cause = '0;
      rec_intr_bits = '0;
      rec_intr_cause = '0;
      rec_nmip = '0;
      rec_rd = '0;
      rec_rd_wdata = '0;
      rec_csr_wmask = '0;
      rec_csr_wdata = '0;
      rec_csr_rdata = '0;
      rec_irq = '0;
      rec_dreq = 1'b0;
      rand_seed = RAND_SEED;
      void'($urandom(rand_seed));
      drive_record();
      records  = 0;

      fd = $fopen(STIM_FILE, "r");
      if (fd == 0) begin
         stop_on_failure("Could not open the stimulus file");
      end

      // Reset falls after time zero so the flops see its edge
      #1;
      arst_n_i = 1'b0;
      for (int c = 0; c < RESET_CYCLES; c++) begin
         wait_falling_edge();
      end
      arst_n_i = 1'b1;

      while ($fgets(line, fd) != 0) begin
         if (line.len() < 2 || line.getc(0) == "#") begin
            continue;
         end
         fields = $sscanf(line,
            "%s %h %h %b %h %h %b %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %b %h %b",
            test_name, rec_valid, rec_order, rec_trap_bits, rec_dbg_cause, rec_exc_cause,
            rec_intr_bits, rec_intr_cause, rec_nmip, rec_rd, rec_rd_wdata, rec_csr_wmask,
            rec_csr_wdata, rec_csr_rdata, rec_irq, rec_dreq, exp_trap, exp_csr, exp_csr_wb,
            exp_x_wb, exp_x_wdata, exp_nmi_cause, exp_fault_bits, exp_nets, exp_net_bits);
         if (fields != 25) begin
            stop_on_failure("A stimulus line has the wrong number of columns");
         end
         drive_record();
         wait_falling_edge();
         check_record();
         records++;
      end
      $fclose(fd);

      if (records == 0) begin
         stop_on_failure("The stimulus file held no records");
      end

      $display("RESULT: PASS");
      $finish;
   end

endmodule

/* tests/rvvi_trace_bridge_assertions.sv */
`timescale 1ns/1ns

module rvvi_trace_bridge_assertions (
   input  logic                                rvvi,
   input  logic                                arst_n_i,
   input  logic                                valid_o,
   input  logic                                trap_o,
   input  logic [rvvi_bridge_pkg::NUM_CSR-1:0] csr_wb_o,
   input  rvvi_bridge_pkg::gpr_mask_t          x_wb_o,
   input  logic                                nmi_o,
   input  rvvi_bridge_pkg::intr_cause_t        nmi_cause_o,
   input  logic                                nmi_change_o,
   input  logic                                ifault_o,
   input  logic                                ifault_change_o,
   input  rvvi_bridge_pkg::irq_nets_t          irq_nets_o,
   input  logic                                haltreq_o,
   input  logic                                irq_change_o,
   input  logic                                haltreq_change_o
);

   int unsigned fail_count = 0;

   // Every reset output stays cleared under reset
   reset_outputs_clear : assert property (@(posedge rvvi) !arst_n_i |->
      ({valid_o, trap_o, csr_wb_o, x_wb_o, nmi_o, nmi_cause_o, nmi_change_o, ifault_o,
        ifault_change_o, irq_nets_o, haltreq_o, irq_change_o, haltreq_change_o} == '0))
      else begin
         fail_count++;
         $error("Trace outputs not cleared while reset is held");
      end

   nmi_strobe_on_change : assert property (@(posedge rvvi) disable iff (!arst_n_i)
      nmi_change_o |-> (nmi_o != $past(nmi_o)))
      else begin
         fail_count++;
         $error("NMI change strobe without a change of the NMI level");
      end

   gpr_mask_onehot : assert property (@(posedge rvvi) disable iff (!arst_n_i)
      $onehot0(x_wb_o))
      else begin
         fail_count++;
         $error("GPR write mask has more than one bit set");
      end

endmodule

/* logic/rvvi_trace_bridge.sv */
`timescale 1ns/1ns

module rvvi_trace_bridge (
   input  logic                         rvvi,
   input  logic                         arst_n_i,
   // Retirement record
   input  logic                         valid_i,
   input  rvvi_bridge_pkg::order_t      order_i,
   input  rvvi_bridge_pkg::xword_t      insn_i,
   input  rvvi_bridge_pkg::xword_t      pc_rdata_i,
   input  rvvi_bridge_pkg::xword_t      pc_wdata_i,
   input  logic                         trap_i,
   input  logic                         trap_exception_i,
   input  logic                         trap_debug_i,
   input  rvvi_bridge_pkg::dbg_cause_t  trap_debug_cause_i,
   input  rvvi_bridge_pkg::exc_cause_t  trap_exc_cause_i,
   input  logic                         intr_i,
   input  logic                         intr_interrupt_i,
   input  rvvi_bridge_pkg::intr_cause_t intr_cause_i,
   input  logic [1:0]                   mode_i,
   input  logic [1:0]                   nmip_i,
   input  rvvi_bridge_pkg::xword_t      csr_rdata_i [rvvi_bridge_pkg::NUM_CSR],
   input  rvvi_bridge_pkg::xword_t      csr_wdata_i [rvvi_bridge_pkg::NUM_CSR],
   input  rvvi_bridge_pkg::xword_t      csr_rmask_i [rvvi_bridge_pkg::NUM_CSR],
   input  rvvi_bridge_pkg::xword_t      csr_wmask_i [rvvi_bridge_pkg::NUM_CSR],
   input  rvvi_bridge_pkg::gpr_idx_t    rd_addr_i,
   input  rvvi_bridge_pkg::xword_t      rd_wdata_i,
   // Core nets
   input  logic [31:0]                  irq_i,
   input  logic                         debug_req_i,
   // Trace outputs
   output logic                         valid_o,
   output rvvi_bridge_pkg::order_t      order_o,
   output rvvi_bridge_pkg::xword_t      insn_o,
   output rvvi_bridge_pkg::xword_t      pc_rdata_o,
   output rvvi_bridge_pkg::xword_t      pc_wdata_o,
   output logic                         trap_o,
   output logic                         intr_o,
   output logic [1:0]                   mode_o,
   output rvvi_bridge_pkg::xword_t      csr_o       [rvvi_bridge_pkg::NUM_CSR],
   output logic [rvvi_bridge_pkg::NUM_CSR-1:0] csr_wb_o,
   output rvvi_bridge_pkg::gpr_mask_t   x_wb_o,
   output rvvi_bridge_pkg::xword_t      x_wdata_o,
   output logic                         nmi_o,
   output rvvi_bridge_pkg::intr_cause_t nmi_cause_o,
   output logic                         nmi_change_o,
   output logic                         ifault_o,
   output logic                         ifault_change_o,
   output rvvi_bridge_pkg::irq_nets_t   irq_nets_o,
   output logic                         haltreq_o,
   output logic                         irq_change_o,
   output logic                         haltreq_change_o
);

   retire_qualifier retire_qualifier_inst (
      .rvvi               (rvvi),
      .arst_n_i           (arst_n_i),
      .valid_i            (valid_i),
      .order_i            (order_i),
      .insn_i             (insn_i),
      .pc_rdata_i         (pc_rdata_i),
      .pc_wdata_i         (pc_wdata_i),
      .trap_i             (trap_i),
      .trap_exception_i   (trap_exception_i),
      .trap_debug_i       (trap_debug_i),
      .trap_debug_cause_i (trap_debug_cause_i),
      .intr_i             (intr_i),
      .mode_i             (mode_i),
      .valid_o            (valid_o),
      .order_o            (order_o),
      .insn_o             (insn_o),
      .pc_rdata_o         (pc_rdata_o),
      .pc_wdata_o         (pc_wdata_o),
      .trap_o             (trap_o),
      .intr_o             (intr_o),
      .mode_o             (mode_o)
   );

   csr_trace_merge csr_trace_merge_inst (
      .rvvi        (rvvi),
      .arst_n_i    (arst_n_i),
      .valid_i     (valid_i),
      .csr_rdata_i (csr_rdata_i),
      .csr_wdata_i (csr_wdata_i),
      .csr_rmask_i (csr_rmask_i),
      .csr_wmask_i (csr_wmask_i),
      .csr_o       (csr_o),
      .csr_wb_o    (csr_wb_o)
   );

   gpr_write_capture gpr_write_capture_inst (
      .rvvi       (rvvi),
      .arst_n_i   (arst_n_i),
      .valid_i    (valid_i),
      .rd_addr_i  (rd_addr_i),
      .rd_wdata_i (rd_wdata_i),
      .x_wb_o     (x_wb_o),
      .x_wdata_o  (x_wdata_o)
   );

   bus_fault_tracker bus_fault_tracker_inst (
      .rvvi             (rvvi),
      .arst_n_i         (arst_n_i),
      .valid_i          (valid_i),
      .order_i          (order_i),
      .trap_i           (trap_i),
      .trap_exception_i (trap_exception_i),
      .trap_exc_cause_i (trap_exc_cause_i),
      .intr_i           (intr_i),
      .intr_interrupt_i (intr_interrupt_i),
      .intr_cause_i     (intr_cause_i),
      .nmip_i           (nmip_i),
      .nmi_o            (nmi_o),
      .nmi_cause_o      (nmi_cause_o),
      .nmi_change_o     (nmi_change_o),
      .ifault_o         (ifault_o),
      .ifault_change_o  (ifault_change_o)
   );

   irq_net_monitor irq_net_monitor_inst (
      .rvvi             (rvvi),
      .arst_n_i         (arst_n_i),
      .irq_i            (irq_i),
      .debug_req_i      (debug_req_i),
      .irq_nets_o       (irq_nets_o),
      .haltreq_o        (haltreq_o),
      .irq_change_o     (irq_change_o),
      .haltreq_change_o (haltreq_change_o)
   );

endmodule

/* logic/irq_net_monitor.sv */
`timescale 1ns/1ns

module irq_net_monitor (
   input  logic                       rvvi,
   input  logic                       arst_n_i,
   input  logic [31:0]                irq_i,
   input  logic                       debug_req_i,
   output rvvi_bridge_pkg::irq_nets_t irq_nets_o,
   output logic                       haltreq_o,
   output logic                       irq_change_o,
   output logic                       haltreq_change_o
);
   import rvvi_bridge_pkg::*;

   irq_nets_t nets;

   // Only the traced lines, the other irq bits are dropped here
   for (genvar n = 0; n < NUM_IRQ_NETS; n++) begin : g_net
      assign nets[n] = irq_i[IRQ_LINE_MAP[n]];
   end

   always_ff @(posedge rvvi or negedge arst_n_i) begin
      if (!arst_n_i) begin
         irq_nets_o       <= '0;
         haltreq_o        <= 1'b0;
         irq_change_o     <= 1'b0;
         haltreq_change_o <= 1'b0;
      end else begin
         irq_nets_o       <= nets;
         haltreq_o        <= debug_req_i;
         irq_change_o     <= |(nets ^ irq_nets_o);
         haltreq_change_o <= debug_req_i ^ haltreq_o;
      end
   end

endmodule

/* logic/bus_fault_tracker.sv */
`timescale 1ns/1ns

module bus_fault_tracker (
   input  logic                         rvvi,
   input  logic                         arst_n_i,
   input  logic                         valid_i,
   input  rvvi_bridge_pkg::order_t      order_i,
   input  logic                         trap_i,
   input  logic                         trap_exception_i,
   input  rvvi_bridge_pkg::exc_cause_t  trap_exc_cause_i,
   input  logic                         intr_i,
   input  logic                         intr_interrupt_i,
   input  rvvi_bridge_pkg::intr_cause_t intr_cause_i,
   input  logic [1:0]                   nmip_i,
   output logic                         nmi_o,
   output rvvi_bridge_pkg::intr_cause_t nmi_cause_o,
   output logic                         nmi_change_o,
   output logic                         ifault_o,
   output logic                         ifault_change_o
);
   import rvvi_bridge_pkg::*;

   fault_state_e state_q;
   order_t       last_order_q;
   logic         accept;
   logic         nmi_hit;
   logic         ifault_hit;

   // Repeated order numbers are the same retirement seen again
   assign accept = valid_i && (order_i != last_order_q);

   assign nmi_hit = (intr_i && intr_interrupt_i &&
                     (intr_cause_i == NMI_CAUSE_LOAD || intr_cause_i == NMI_CAUSE_STORE)) ||
                    nmip_i[0];
   assign ifault_hit = trap_i && trap_exception_i && (trap_exc_cause_i == EXC_INSTR_BUS_FAULT);

   assign nmi_o = (state_q == NMI_ACTIVE);

   always_ff @(posedge rvvi or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q         <= NMI_IDLE;
         last_order_q    <= '0;
         nmi_cause_o     <= '0;
         nmi_change_o    <= 1'b0;
         ifault_o        <= 1'b0;
         ifault_change_o <= 1'b0;
      end else begin
         nmi_change_o    <= 1'b0;
         ifault_change_o <= 1'b0;
         if (accept) begin
            last_order_q    <= order_i;
            ifault_o        <= ifault_hit;
            ifault_change_o <= ifault_hit ^ ifault_o;
            if (nmi_hit) begin
               nmi_cause_o <= intr_cause_i;
            end
            case (state_q)
               NMI_IDLE: begin
                  if (nmi_hit) begin
                     state_q      <= NMI_ACTIVE;
                     nmi_change_o <= 1'b1;
                  end
               end
               NMI_ACTIVE: begin
                  if (!nmi_hit) begin
                     state_q      <= NMI_IDLE;
                     nmi_change_o <= 1'b1;
                  end
               end
            endcase
         end
      end
   end

endmodule

/* logic/gpr_write_capture.sv */
`timescale 1ns/1ns

module gpr_write_capture (
   input  logic                      rvvi,
   input  logic                      arst_n_i,
   input  logic                      valid_i,
   input  rvvi_bridge_pkg::gpr_idx_t rd_addr_i,
   input  rvvi_bridge_pkg::xword_t   rd_wdata_i,
   output rvvi_bridge_pkg::gpr_mask_t x_wb_o,
   output rvvi_bridge_pkg::xword_t   x_wdata_o
);
   import rvvi_bridge_pkg::*;

   logic      gpr_we;
   gpr_mask_t wb_d;

   // x0 is hardwired, so a write to it is not traced
   assign gpr_we = valid_i && (rd_addr_i != '0);
   assign wb_d   = gpr_we ? (gpr_mask_t'(1) << rd_addr_i) : '0;

   always_ff @(posedge rvvi or negedge arst_n_i) begin
      if (!arst_n_i) begin
         x_wb_o <= '0;
      end else begin
         x_wb_o <= wb_d;
      end
   end

   // Data holds its last written value
   always_ff @(posedge rvvi) begin
      if (gpr_we) begin
         x_wdata_o <= rd_wdata_i;
      end
   end

endmodule

/* logic/csr_trace_merge.sv */
`timescale 1ns/1ns

module csr_trace_merge (
   input  logic                               rvvi,
   input  logic                               arst_n_i,
   input  logic                               valid_i,
   input  rvvi_bridge_pkg::xword_t            csr_rdata_i [rvvi_bridge_pkg::NUM_CSR],
   input  rvvi_bridge_pkg::xword_t            csr_wdata_i [rvvi_bridge_pkg::NUM_CSR],
   input  rvvi_bridge_pkg::xword_t            csr_rmask_i [rvvi_bridge_pkg::NUM_CSR],
   input  rvvi_bridge_pkg::xword_t            csr_wmask_i [rvvi_bridge_pkg::NUM_CSR],
   output rvvi_bridge_pkg::xword_t            csr_o       [rvvi_bridge_pkg::NUM_CSR],
   output logic [rvvi_bridge_pkg::NUM_CSR-1:0] csr_wb_o
);
   import rvvi_bridge_pkg::*;

   logic [NUM_CSR-1:0] touched;

   always_comb begin
      for (int i = 0; i < NUM_CSR; i++) begin
         touched[i] = (|csr_rmask_i[i]) || (|csr_wmask_i[i]);
      end
   end

   // Written bits from wdata, the rest from rdata
   always_ff @(posedge rvvi) begin
      for (int i = 0; i < NUM_CSR; i++) begin
         csr_o[i] <= (csr_wdata_i[i] & csr_wmask_i[i]) | (csr_rdata_i[i] & ~csr_wmask_i[i]);
      end
   end

   // A new access wins over the clear from a valid retirement
   always_ff @(posedge rvvi or negedge arst_n_i) begin
      if (!arst_n_i) begin
         csr_wb_o <= '0;
      end else begin
         for (int i = 0; i < NUM_CSR; i++) begin
            if (touched[i]) begin
               csr_wb_o[i] <= 1'b1;
            end else if (valid_i) begin
               csr_wb_o[i] <= 1'b0;
            end
         end
      end
   end

endmodule

/* logic/retire_qualifier.sv */
`timescale 1ns/1ns

module retire_qualifier (
   input  logic                        rvvi,
   input  logic                        arst_n_i,
   input  logic                        valid_i,
   input  rvvi_bridge_pkg::order_t     order_i,
   input  rvvi_bridge_pkg::xword_t     insn_i,
   input  rvvi_bridge_pkg::xword_t     pc_rdata_i,
   input  rvvi_bridge_pkg::xword_t     pc_wdata_i,
   input  logic                        trap_i,
   input  logic                        trap_exception_i,
   input  logic                        trap_debug_i,
   input  rvvi_bridge_pkg::dbg_cause_t trap_debug_cause_i,
   input  logic                        intr_i,
   input  logic [1:0]                  mode_i,
   output logic                        valid_o,
   output rvvi_bridge_pkg::order_t     order_o,
   output rvvi_bridge_pkg::xword_t     insn_o,
   output rvvi_bridge_pkg::xword_t     pc_rdata_o,
   output rvvi_bridge_pkg::xword_t     pc_wdata_o,
   output logic                        trap_o,
   output logic                        intr_o,
   output logic [1:0]                  mode_o
);
   import rvvi_bridge_pkg::*;

   logic dbg_no_retire;
   logic trap_d;

   // Ebreak and trigger match into debug never retire
   assign dbg_no_retire = trap_debug_i &&
                          (trap_debug_cause_i == DBG_CAUSE_EBREAK ||
                           trap_debug_cause_i == DBG_CAUSE_TRIGGER);
   assign trap_d = valid_i && trap_i && (trap_exception_i || dbg_no_retire);

   always_ff @(posedge rvvi or negedge arst_n_i) begin
      if (!arst_n_i) begin
         valid_o <= 1'b0;
         trap_o  <= 1'b0;
      end else begin
         valid_o <= valid_i;
         trap_o  <= trap_d;
      end
   end

   // Record payload
   always_ff @(posedge rvvi) begin
      order_o    <= order_i;
      insn_o     <= insn_i;
      pc_rdata_o <= pc_rdata_i;
      pc_wdata_o <= pc_wdata_i;
      intr_o     <= intr_i;
      mode_o     <= mode_i;
   end

endmodule

/* logic/rvvi_bridge_pkg.sv */
package rvvi_bridge_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // Trace widths
   ////////////////////////////////////////////////////////////////////////////
   localparam int unsigned XLEN = 32;

   typedef logic [XLEN-1:0] xword_t;
   typedef logic [63:0]     order_t;
   typedef logic [4:0]      gpr_idx_t;
   typedef logic [31:0]     gpr_mask_t;

   ////////////////////////////////////////////////////////////////////////////
   // Traced CSR slots
   ////////////////////////////////////////////////////////////////////////////
   localparam int unsigned NUM_CSR = 4;

   typedef logic [1:0] csr_sel_t;

   localparam csr_sel_t CSR_MSTATUS_SLOT = 2'd0;  // mstatus, 0x300
   localparam csr_sel_t CSR_MEPC_SLOT    = 2'd1;  // mepc, 0x341
   localparam csr_sel_t CSR_MCAUSE_SLOT  = 2'd2;  // mcause, 0x342
   localparam csr_sel_t CSR_MTVAL_SLOT   = 2'd3;  // mtval, 0x343

   ////////////////////////////////////////////////////////////////////////////
   // Trap, debug and interrupt causes
   ////////////////////////////////////////////////////////////////////////////
   typedef logic [5:0]  exc_cause_t;
   typedef logic [2:0]  dbg_cause_t;
   typedef logic [10:0] intr_cause_t;

   localparam exc_cause_t  EXC_INSTR_BUS_FAULT = 6'd24;
   localparam dbg_cause_t  DBG_CAUSE_EBREAK    = 3'd1;
   localparam dbg_cause_t  DBG_CAUSE_TRIGGER   = 3'd2;
   // Data bus errors reported as NMI
   localparam intr_cause_t NMI_CAUSE_LOAD      = 11'd1024;
   localparam intr_cause_t NMI_CAUSE_STORE     = 11'd1025;

   ////////////////////////////////////////////////////////////////////////////
   // Interrupt nets
   ////////////////////////////////////////////////////////////////////////////
   localparam int unsigned NUM_IRQ_NETS = 19;

   typedef logic [NUM_IRQ_NETS-1:0] irq_nets_t;

   // Software, timer, external, then local interrupts 0 to 15
   localparam int unsigned IRQ_LINE_MAP [NUM_IRQ_NETS] = '{
      3, 7, 11, 16, 17, 18, 19, 20, 21, 22, 23, 24, 25, 26, 27, 28, 29, 30, 31
   };

   typedef enum logic {
      NMI_IDLE,
      NMI_ACTIVE
   } fault_state_e;

endpackage
